//--- cpuIf_config.svh
`ifndef CPU_IF_CONFIG_SVH
`define CPU_IF_CONFIG_SVH

// ************************************************************
// Bus widths.
// ************************************************************

`define CPU_ADR_W   18
`define DATA_W      32
`define SRAM_ADR_W  12
`define BANK_W      6

// ************************************************************
// Bank map. Codes 0x2F and 0x32..0x3F are unused.
// ************************************************************

// Weight banks take codes 0 .. NUM_SRAM-1.
`define NUM_SRAM    46
`define NUM_RESULT  46

`define BIAS_BANK   6'h2E
`define IMAGE_BANK  6'h30
`define RESULT_BANK 6'h31

`endif

//--- cpuIfPkg.sv
`include "cpuIf_config.svh"

package cpuIfPkg;

   // ************************************************************
   // Data and select types.
   // ************************************************************

   typedef logic [`DATA_W-1:0] word_t;

   // One bit per weight bank.
   typedef logic [`NUM_SRAM-1:0] sramSel_t;

   // Result i sits in element i.
   typedef word_t [`NUM_RESULT-1:0] resultBus_t;

   // ************************************************************
   // CPU address views.
   // ************************************************************

   // Write view: bank code on top, in-bank offset below.
   typedef struct packed {
      logic [`BANK_W-1:0]     bank;
      logic [`SRAM_ADR_W-1:0] offset;
   } sramAddr_t;

   // Readback view: the offset splits into word index and byte lane.
   typedef struct packed {
      logic [`BANK_W-1:0]       bank;
      logic [`SRAM_ADR_W-3:0]   index;
      logic [1:0]               lane;
   } resultAddr_t;

   // Both views cover the full CPU address.
   typedef union packed {
      sramAddr_t   sram;
      resultAddr_t result;
   } cpuAddr_u;

endpackage

//--- cpuBusIf.sv
`include "cpuIf_config.svh"

interface cpuBusIf;

   // Write strobe and read strobe, plain levels with no handshake.
   logic wr;
   logic rd;

   // Byte address and write data from the host.
   logic [`CPU_ADR_W-1:0] adr;
   logic [`DATA_W-1:0]    wdata;

   // ************************************************************
   // Consumer views.
   // ************************************************************

   // Bank decode and SRAM write path.
   modport decode (
      input wr,
      input adr,
      input wdata
   );

   // Result readback mux.
   modport readback (
      input rd,
      input adr
   );

endinterface

//--- sramWriteDecode.sv
`include "cpuIf_config.svh"

module sramWriteDecode (
   input  logic                   CLK,
   input  logic                   RESET_X,

   cpuBusIf.decode                bus,

   output cpuIfPkg::sramSel_t     sramSel,
   output logic                   biasSel,
   output logic                   imageSel,
   output logic                   sramWr,
   output logic [`SRAM_ADR_W-1:0] sramAdr,
   output cpuIfPkg::word_t        sramData
);

   cpuIfPkg::cpuAddr_u addr;
   cpuIfPkg::sramSel_t selNext;
   logic               biasNext;
   logic               imageNext;

   assign addr = bus.adr;

   // ************************************************************
   // Bank decode.
   // ************************************************************

   // One-hot over the weight banks, empty above NUM_SRAM.
   always_comb begin
      selNext = '0;
      if (addr.sram.bank < `BANK_W'(`NUM_SRAM)) begin
         selNext[addr.sram.bank] = 1'b1;
      end
   end

   assign biasNext  = (addr.sram.bank == `BIAS_BANK);
   assign imageNext = (addr.sram.bank == `IMAGE_BANK);

   // Selects track the address every cycle, write or not.
   always_ff @(posedge CLK or negedge RESET_X) begin
      if (!RESET_X) begin
         sramSel  <= '0;
         biasSel  <= 1'b0;
         imageSel <= 1'b0;
      end
      else begin
         sramSel  <= selNext;
         biasSel  <= biasNext;
         imageSel <= imageNext;
      end
   end

   // ************************************************************
   // Write path.
   // ************************************************************

   // Same stage as the selects so strobe and select line up.
   always_ff @(posedge CLK or negedge RESET_X) begin
      if (!RESET_X) begin
         sramWr <= 1'b0;
      end
      else begin
         sramWr <= bus.wr;
      end
   end

   // Offset and data pass through unchanged.
   always_ff @(posedge CLK or negedge RESET_X) begin
      if (!RESET_X) begin
         sramAdr  <= '0;
         sramData <= '0;
      end
      else begin
         sramAdr  <= addr.sram.offset;
         sramData <= bus.wdata;
      end
   end

endmodule

//--- resultReadback.sv
`include "cpuIf_config.svh"

module resultReadback (
   input  logic                   CLK,
   input  logic                   RESET_X,

   cpuBusIf.readback              bus,

   input  cpuIfPkg::resultBus_t   results,
   output cpuIfPkg::word_t        rdata
);

   localparam int IDX_W = $clog2(`NUM_RESULT);

   cpuIfPkg::cpuAddr_u addr;
   logic [IDX_W-1:0]   idx;
   logic               hit;
   cpuIfPkg::word_t    rdataNext;

   assign addr = bus.adr;

   // ************************************************************
   // Address check.
   // ************************************************************

   // Word-aligned reads inside the result window only.
   assign hit = (addr.result.bank == `RESULT_BANK)
             && (addr.result.lane == 2'b00)
             && (addr.result.index < (`SRAM_ADR_W-2)'(`NUM_RESULT));

   // Low bits are enough once the range check has passed.
   assign idx = addr.result.index[IDX_W-1:0];

   // ************************************************************
   // Read mux and output register.
   // ************************************************************

   always_comb begin
      rdataNext = '0;
      if (hit) begin
         rdataNext = results[idx];
      end
   end

   // Loaded on a read strobe, held otherwise.
   always_ff @(posedge CLK or negedge RESET_X) begin
      if (!RESET_X) begin
         rdata <= '0;
      end
      else if (bus.rd) begin
         rdata <= rdataNext;
      end
   end

endmodule

//--- cpuIf.sv
`include "cpuIf_config.svh"

module cpuIf (
   input  logic                   CLK,
   input  logic                   RESET_X,

   // Host bus.
   input  logic                   CPU_WR,
   input  logic                   CPU_RD,
   input  logic [`CPU_ADR_W-1:0]  CPU_ADR,
   input  cpuIfPkg::word_t        CPU_WDATA,
   output cpuIfPkg::word_t        CPU_RDATA,

   // SRAM side.
   output logic [`SRAM_ADR_W-1:0] SRAM_ADR,
   output cpuIfPkg::sramSel_t     SRAM_SEL,
   output logic                   BIAS_SEL,
   output logic                   IMAGE_SEL,
   output logic                   SRAM_BIAS_IMG_WR,
   output cpuIfPkg::word_t        SRAM_DATA,

   // Accelerator outputs for readback.
   input  cpuIfPkg::resultBus_t   RESULTS
);

   // ************************************************************
   // Host bus into the shared interface.
   // ************************************************************

   cpuBusIf bus ();

   assign bus.wr    = CPU_WR;
   assign bus.rd    = CPU_RD;
   assign bus.adr   = CPU_ADR;
   assign bus.wdata = CPU_WDATA;

   // ************************************************************
   // Write side.
   // ************************************************************

   sramWriteDecode writeDecode0 (
      .CLK      (CLK),
      .RESET_X  (RESET_X),
      .bus      (bus.decode),
      .sramSel  (SRAM_SEL),
      .biasSel  (BIAS_SEL),
      .imageSel (IMAGE_SEL),
      .sramWr   (SRAM_BIAS_IMG_WR),
      .sramAdr  (SRAM_ADR),
      .sramData (SRAM_DATA)
   );

   // ************************************************************
   // Read side.
   // ************************************************************

   // Results are mapped at 0x31000 + 4*i.
   resultReadback readback0 (
      .CLK     (CLK),
      .RESET_X (RESET_X),
      .bus     (bus.readback),
      .results (RESULTS),
      .rdata   (CPU_RDATA)
   );

endmodule

//--- cpuIf_checker.sv
module cpuIfChecker (
   input logic               CLK,
   input logic               RESET_X,
   input logic               CPU_RD,
   input cpuIfPkg::word_t    CPU_RDATA,
   input cpuIfPkg::sramSel_t SRAM_SEL,
   input logic               BIAS_SEL,
   input logic               IMAGE_SEL
);

   timeunit 1ns;
   timeprecision 100ps;

   // ************************************************************
   // Select rules.
   // ************************************************************

   // At most one weight bank at a time.
   sramSelOneHot: assert property (@(posedge CLK) disable iff (!RESET_X)
      $onehot0(SRAM_SEL))
      else $error("SRAM_SEL has more than one weight bank selected");

   // Weight, bias and image never together.
   selectExclusive: assert property (@(posedge CLK) disable iff (!RESET_X)
      $onehot0({|SRAM_SEL, BIAS_SEL, IMAGE_SEL}))
      else $error("Weight, bias and image selects are active together");

   // ************************************************************
   // Readback rule.
   // ************************************************************

   rdataHold: assert property (@(posedge CLK) disable iff (!RESET_X)
      !CPU_RD |=> $stable(CPU_RDATA))
      else $error("CPU_RDATA changed after a cycle without a read strobe");

endmodule

bind cpuIf cpuIfChecker checker0 (
   .CLK       (CLK),
   .RESET_X   (RESET_X),
   .CPU_RD    (CPU_RD),
   .CPU_RDATA (CPU_RDATA),
   .SRAM_SEL  (SRAM_SEL),
   .BIAS_SEL  (BIAS_SEL),
   .IMAGE_SEL (IMAGE_SEL)
);

//--- tbCpuIf.sv
`include "cpuIf_config.svh"

module tbCpuIf;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 8;
   localparam int DECODE_CYCLES   = `NUM_SRAM;
   localparam int SPECIAL_CYCLES  = 64 - `NUM_SRAM;
   localparam int WRITE_CYCLES    = 200;
   localparam int READ_CYCLES     = 2 * `NUM_RESULT;
   localparam int BAD_READ_ROUNDS = 10;
   localparam int BAD_READ_CYCLES = 6 * BAD_READ_ROUNDS;
   localparam int DRAIN_CYCLES    = 4;
   localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 1 + DECODE_CYCLES + SPECIAL_CYCLES
                                  + WRITE_CYCLES + READ_CYCLES + BAD_READ_CYCLES
                                  + DRAIN_CYCLES + 100;
   localparam int IDX_W           = $clog2(`NUM_RESULT);

   // Unused bank code so that no select fires while idle.
   localparam logic [`CPU_ADR_W-1:0] IDLE_ADR = 18'h3F000;

   // Expected write side outputs of one cycle.
   typedef struct packed {
      cpuIfPkg::sramSel_t     sel;
      logic                   bias;
      logic                   image;
      logic                   wr;
      logic [`SRAM_ADR_W-1:0] adr;
      cpuIfPkg::word_t        data;
   } writeSide_t;

   logic                   CLK;
   logic                   RESET_X;
   logic                   CPU_WR;
   logic                   CPU_RD;
   logic [`CPU_ADR_W-1:0]  CPU_ADR;
   cpuIfPkg::word_t        CPU_WDATA;
   cpuIfPkg::word_t        CPU_RDATA;
   logic [`SRAM_ADR_W-1:0] SRAM_ADR;
   cpuIfPkg::sramSel_t     SRAM_SEL;
   logic                   BIAS_SEL;
   logic                   IMAGE_SEL;
   logic                   SRAM_BIAS_IMG_WR;
   cpuIfPkg::word_t        SRAM_DATA;
   cpuIfPkg::resultBus_t   RESULTS;

   writeSide_t             expWrite;
   cpuIfPkg::word_t        expRdata;
   logic [31:0]            lcgState;

   cpuIf dut0 (
      .CLK              (CLK),
      .RESET_X          (RESET_X),
      .CPU_WR           (CPU_WR),
      .CPU_RD           (CPU_RD),
      .CPU_ADR          (CPU_ADR),
      .CPU_WDATA        (CPU_WDATA),
      .CPU_RDATA        (CPU_RDATA),
      .SRAM_ADR         (SRAM_ADR),
      .SRAM_SEL         (SRAM_SEL),
      .BIAS_SEL         (BIAS_SEL),
      .IMAGE_SEL        (IMAGE_SEL),
      .SRAM_BIAS_IMG_WR (SRAM_BIAS_IMG_WR),
      .SRAM_DATA        (SRAM_DATA),
      .RESULTS          (RESULTS)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   // ************************************************************
   // Helpers.
   // ************************************************************

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return {lcgState[31:16], lcgState[31:16] ^ lcgState[15:0]};
   endfunction

   function automatic logic [`CPU_ADR_W-1:0] bankAddress(input int bank,
                                                         input logic [`SRAM_ADR_W-1:0] offset);
      return {`BANK_W'(bank), offset};
   endfunction

   function automatic logic [`CPU_ADR_W-1:0] resultAddress(input int bank, input int idx,
                                                           input logic [1:0] lane);
      return {`BANK_W'(bank), 10'(idx), lane};
   endfunction

   // Bank code sits in the top bits and is one-hot below NUM_SRAM.
   function automatic writeSide_t expectedWrite(input logic wr,
                                                input logic [`CPU_ADR_W-1:0] adr,
                                                input cpuIfPkg::word_t wdata);
      writeSide_t         outs;
      logic [`BANK_W-1:0] bank;
      int                 k;
      bank = adr[`CPU_ADR_W-1:`SRAM_ADR_W];
      outs = '0;
      for (k = 0; k < `NUM_SRAM; k++) begin
         outs.sel[k] = (bank == `BANK_W'(k));
      end
      outs.bias  = (bank == `BIAS_BANK);
      outs.image = (bank == `IMAGE_BANK);
      outs.wr    = wr;
      outs.adr   = adr[`SRAM_ADR_W-1:0];
      outs.data  = wdata;
      return outs;
   endfunction

   // Result i lives at 0x31000 + 4*i and everything else reads zero.
   function automatic cpuIfPkg::word_t expectedRead(input logic [`CPU_ADR_W-1:0] adr,
                                                    input cpuIfPkg::resultBus_t results);
      logic [`BANK_W-1:0]     bank;
      logic [`SRAM_ADR_W-3:0] wordIdx;
      logic [IDX_W-1:0]       idx;
      bank    = adr[`CPU_ADR_W-1:`SRAM_ADR_W];
      wordIdx = adr[`SRAM_ADR_W-1:2];
      idx     = wordIdx[IDX_W-1:0];
      if (bank == `RESULT_BANK && adr[1:0] == 2'b00 && int'(wordIdx) < `NUM_RESULT) begin
         return results[idx];
      end
      return '0;
   endfunction

   task automatic checkValue(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic driveCycle(input logic wr, input logic rd, input logic [`CPU_ADR_W-1:0] adr,
                             input cpuIfPkg::word_t wdata);
      @(posedge CLK);
      #1;
      CPU_WR    = wr;
      CPU_RD    = rd;
      CPU_ADR   = adr;
      CPU_WDATA = wdata;
   endtask

   task automatic refreshResults();
      int i;
      for (i = 0; i < `NUM_RESULT; i++) begin
         RESULTS[i] = nextRandom();
      end
   endtask

   // ************************************************************
   // Model and comparison.
   // ************************************************************

   always @(posedge CLK) begin
      if (!RESET_X) begin
         expWrite <= '0;
         expRdata <= '0;
      end
      else begin
         expWrite <= expectedWrite(CPU_WR, CPU_ADR, CPU_WDATA);
         if (CPU_RD) begin
            expRdata <= expectedRead(CPU_ADR, RESULTS);
         end
      end
   end

   // The model holds a value from the first rising edge on.
   initial begin
      @(posedge CLK);
      forever begin
         @(negedge CLK);
         checkValue("SRAM_SEL", 64'(SRAM_SEL), 64'(expWrite.sel));
         checkValue("BIAS_SEL", 64'(BIAS_SEL), 64'(expWrite.bias));
         checkValue("IMAGE_SEL", 64'(IMAGE_SEL), 64'(expWrite.image));
         checkValue("SRAM_BIAS_IMG_WR", 64'(SRAM_BIAS_IMG_WR), 64'(expWrite.wr));
         checkValue("SRAM_ADR", 64'(SRAM_ADR), 64'(expWrite.adr));
         checkValue("SRAM_DATA", 64'(SRAM_DATA), 64'(expWrite.data));
         checkValue("CPU_RDATA", 64'(CPU_RDATA), 64'(expRdata));
      end
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests finished", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "Simulation timed out");
   end

   // ************************************************************
   // Stimulus.
   // ************************************************************

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      int          k;
      int          bank;
      CLK        = 1'b0;
      RESET_X    = 1'b0;
      CPU_WR     = 1'b0;
      CPU_RD     = 1'b0;
      CPU_ADR    = IDLE_ADR;
      CPU_WDATA  = '0;
      RESULTS    = '0;
      lcgState   = 32'd69192;

      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      RESET_X = 1'b1;

      // Every weight bank with a random offset and strobe.
      for (k = 0; k < `NUM_SRAM; k++) begin
         r = nextRandom();
         d = nextRandom();
         driveCycle(r[31], 1'b0, bankAddress(k, r[11:0]), d);
      end

      // Bias, image and the unused codes.
      for (k = `NUM_SRAM; k < 64; k++) begin
         r = nextRandom();
         driveCycle(r[31], 1'b0, bankAddress(k, r[11:0]), nextRandom());
      end

      for (k = 0; k < WRITE_CYCLES; k++) begin
         r = nextRandom();
         d = nextRandom();
         driveCycle(r[30], 1'b0, r[`CPU_ADR_W-1:0], d);
      end

      // Each result read is followed by an idle cycle with new results.
      refreshResults();
      for (k = 0; k < `NUM_RESULT; k++) begin
         r = nextRandom();
         driveCycle(r[31], 1'b1, resultAddress(`RESULT_BANK, k, 2'b00), nextRandom());
         r = nextRandom();
         driveCycle(r[31], 1'b0, r[`CPU_ADR_W-1:0], nextRandom());
         refreshResults();
      end

      // A good read goes ahead of each bad one so that a zero really shows.
      for (k = 0; k < BAD_READ_ROUNDS; k++) begin
         r = nextRandom();
         driveCycle(1'b0, 1'b1,
                    resultAddress(`RESULT_BANK, int'(r[15:0] % 16'd46), 2'b00), '0);
         driveCycle(1'b0, 1'b1,
                    resultAddress(`RESULT_BANK, int'(r[15:0] % 16'd46),
                                  2'(1 + int'(r[17:16]) % 3)), '0);
         r = nextRandom();
         driveCycle(1'b0, 1'b1,
                    resultAddress(`RESULT_BANK, int'(r[15:0] % 16'd46), 2'b00), '0);
         driveCycle(1'b0, 1'b1,
                    resultAddress(`RESULT_BANK, 46 + int'(r[15:0] % 16'd978), 2'b00), '0);
         r = nextRandom();
         bank = int'(r[21:16]);
         if (bank == 'h31) begin
            bank = 'h32;
         end
         driveCycle(1'b0, 1'b1,
                    resultAddress(`RESULT_BANK, int'(r[15:0] % 16'd46), 2'b00), '0);
         driveCycle(1'b0, 1'b1, resultAddress(bank, int'(r[15:0] % 16'd46), 2'b00), '0);
      end

      for (k = 0; k < DRAIN_CYCLES; k++) begin
         driveCycle(1'b0, 1'b0, IDLE_ADR, '0);
      end
      @(negedge CLK);
      #1;

      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
cpuIfPkg.sv
cpuBusIf.sv
sramWriteDecode.sv
resultReadback.sv
cpuIf.sv
cpuIf_checker.sv
tbCpuIf.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert -j 0 --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps
TOP        := tbCpuIf
RTL_TOP    := cpuIf
FILELIST   := filelist.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

# Build and run; the exit status of the simulation is the test result.
all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
